/* tb.f */
+incdir+design
design/isaPkg.sv
design/predictorPkg.sv
design/bankIf.sv
design/updateRouter.sv
design/btbBank.sv
design/predictSelect.sv
design/branchPredictor.sv
verification/predictorChecker.sv
verification/tbBranchPredictor.sv

/* Makefile */
TOP := tbBranchPredictor
SIM := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): tb.f $(wildcard design/*) $(wildcard verification/*)
	verilator --binary --timing -f tb.f --top-module $(TOP)

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)
	verilator --lint-only -f tb.f --top-module branchPredictor

clean:
	rm -rf obj_dir sim.log

/* verification/tbBranchPredictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tbBranchPredictor import isaPkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int DIRECTED_CYCLES = 150;
    localparam int RANDOM_CYCLES = 3000;
    localparam int CYCLE_LIMIT = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;

    logic clk;
    logic rstN;
    logic fetchValid;
    addrT fetchPc;
    logic redirectValid;
    addrT redirectPc;
    addrT nextPc;
    logic predTaken;
    logic updValid;
    addrT updPc;
    addrT updTarget;
    logic updTaken;
    logic updReady;

    logic [31:0] lfsr;
    int checkErrors;
    int tbErrors = 0;
    int errorsAtStart = 0;
    int passCount = 0;
    int failCount = 0;
    int cycleCount = 0;

    branchPredictor dut (.*);

    predictorChecker refCheck (.*, .errorCount(checkErrors));

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic nextBit();
        logic out;
        out = lfsr[0];
        lfsr = out ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return out;
    endfunction

    function automatic addrT randBits(int n);
        addrT val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val = {val[30:0], nextBit()};
        end
        return val;
    endfunction

    // A small pool so that tags alias within a slot and banks collide
    function automatic addrT poolPc();
        return 32'h0000_4000 | (randBits(6) << 2);
    endfunction

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic sendUpdate(input addrT pc, input addrT target, input logic taken);
        logic done;
        done = 1'b0;
        updValid = 1'b1;
        updPc = pc;
        updTarget = target;
        updTaken = taken;
        while (!done) begin
            @(negedge clk);
            done = updReady;
            stepCycle();
        end
        updValid = 1'b0;
    endtask

    task automatic lookupExpect(input addrT pc, input logic expTaken, input addrT expNext,
                                input string what);
        fetchValid = 1'b1;
        fetchPc = pc;
        @(negedge clk);
        if (predTaken !== expTaken || nextPc !== expNext) begin
            $display("Mismatch at %0t: %s lookup of %h gave %h/%b, expected %h/%b", $time,
                     what, pc, nextPc, predTaken, expNext, expTaken);
            tbErrors++;
        end
        stepCycle();
        fetchValid = 1'b0;
    endtask

    task automatic runRandomMix(input int cycles);
        logic fired;
        repeat (cycles) begin
            @(negedge clk);
            fired = updValid && updReady;
            stepCycle();
            fetchValid = (randBits(2) != 32'd0);
            fetchPc = poolPc();
            redirectValid = (randBits(3) == 32'd0);
            redirectPc = randBits(30) << 2;
            if (!updValid || fired) begin
                updValid = nextBit();
                updPc = poolPc();
                updTarget = randBits(30) << 2;
                updTaken = nextBit();
            end
        end
        fetchValid = 1'b0;
        redirectValid = 1'b0;
        // An offered update stays valid until the DUT takes it
        if (updValid) begin
            sendUpdate(updPc, updTarget, updTaken);
        end
    endtask

    task automatic finishTest(input string name);
        if (tbErrors + checkErrors == errorsAtStart) begin
            passCount++;
            $display("Test %s: passed", name);
        end else begin
            failCount++;
            $display("Test %s: FAILED", name);
        end
        errorsAtStart = tbErrors + checkErrors;
    endtask

    initial begin
        addrT pc;
        addrT pcA;
        addrT pcB;
        addrT pcC;
        clk = 1'b0;
        rstN = 1'b0;
        fetchValid = 1'b0;
        fetchPc = '0;
        redirectValid = 1'b0;
        redirectPc = '0;
        updValid = 1'b0;
        updPc = '0;
        updTarget = '0;
        updTaken = 1'b0;
        lfsr = 32'he12d_252d;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;

        repeat (16) begin
            pc = randBits(30) << 2;
            lookupExpect(pc, 1'b0, pc + 32'd4, "empty table");
        end
        @(negedge clk);
        if (updReady !== 1'b1) begin
            $display("Mismatch at %0t: updReady is low with no update held", $time);
            tbErrors++;
        end
        stepCycle();
        finishTest("afterReset");

        pcA = 32'h0000_1010;
        pcB = 32'h0000_1024;
        sendUpdate(pcA, 32'h0000_2000, 1'b1);
        sendUpdate(pcB, 32'h0000_2400, 1'b0);
        repeat (2) stepCycle();
        lookupExpect(pcA, 1'b1, 32'h0000_2000, "allocated");
        lookupExpect(pcB, 1'b0, pcB + 32'd4, "not-taken miss");
        finishTest("allocation");

        repeat (2) sendUpdate(pcA, 32'h0000_2000, 1'b0);
        repeat (2) stepCycle();
        lookupExpect(pcA, 1'b0, pcA + 32'd4, "trained down");
        repeat (3) sendUpdate(pcA, 32'h0000_2000, 1'b1);
        repeat (2) stepCycle();
        lookupExpect(pcA, 1'b1, 32'h0000_2000, "trained up");
        // Two more taken must saturate, so one not-taken still leaves it taken
        repeat (2) sendUpdate(pcA, 32'h0000_2000, 1'b1);
        sendUpdate(pcA, 32'h0000_2000, 1'b0);
        repeat (2) stepCycle();
        lookupExpect(pcA, 1'b1, 32'h0000_2000, "saturated");
        finishTest("counterTraining");

        pcC = pcA + 32'h0000_0080;
        lookupExpect(pcC, 1'b0, pcC + 32'd4, "aliased tag");
        sendUpdate(pcC, 32'h0000_3000, 1'b1);
        repeat (2) stepCycle();
        lookupExpect(pcC, 1'b1, 32'h0000_3000, "replacing tag");
        lookupExpect(pcA, 1'b0, pcA + 32'd4, "replaced tag");
        finishTest("tagCheck");

        redirectValid = 1'b1;
        repeat (8) begin
            redirectPc = randBits(30) << 2;
            pc = nextBit() ? pcC : (randBits(30) << 2);
            lookupExpect(pc, 1'b0, redirectPc, "redirect");
        end
        redirectValid = 1'b0;
        finishTest("redirect");

        runRandomMix(RANDOM_CYCLES);
        repeat (2) stepCycle();
        finishTest("randomMix");

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && tbErrors + checkErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/predictorChecker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "predictor_consts.svh"

module predictorChecker import isaPkg::*; import predictorPkg::*; (
    input wire logic clk,
    input wire logic rstN,
    input wire logic fetchValid,
    input wire addrT fetchPc,
    input wire logic redirectValid,
    input wire addrT redirectPc,
    input wire addrT nextPc,
    input wire logic predTaken,
    input wire logic updValid,
    input wire addrT updPc,
    input wire addrT updTarget,
    input wire logic updTaken,
    input wire logic updReady,
    output int errorCount
);

    logic entryValid [`NUM_BANKS][`BANK_ENTRIES];
    addrT entryTag [`NUM_BANKS][`BANK_ENTRIES];
    addrT entryTarget [`NUM_BANKS][`BANK_ENTRIES];
    logic [1:0] entryCount [`NUM_BANKS][`BANK_ENTRIES];

    // Model of the single update register in front of the banks
    logic heldFull;
    resolveT held;

    // A bank is busy while fetch is looking it up
    function automatic logic bankBusy(addrT pc);
        return fetchValid && (fetchPc[`BANK_MSB:`BANK_LSB] == pc[`BANK_MSB:`BANK_LSB]);
    endfunction

    task automatic writeEntry(input resolveT upd);
        bankSelT b;
        entryIdxT i;
        b = upd.pc[`BANK_MSB:`BANK_LSB];
        i = upd.pc[`INDEX_MSB:`INDEX_LSB];
        if (entryValid[b][i] && entryTag[b][i] == upd.pc) begin
            if (upd.taken && entryCount[b][i] != 2'd3) begin
                entryCount[b][i] = entryCount[b][i] + 2'd1;
            end else if (!upd.taken && entryCount[b][i] != 2'd0) begin
                entryCount[b][i] = entryCount[b][i] - 2'd1;
            end
        end else if (upd.taken) begin
            entryValid[b][i] = 1'b1;
            entryTag[b][i] = upd.pc;
            entryTarget[b][i] = upd.target;
            entryCount[b][i] = weakTaken;
        end
    endtask

    always @(posedge clk) begin
        logic drain;
        logic accept;
        if (!rstN) begin
            for (int b = 0; b < `NUM_BANKS; b++) begin
                for (int i = 0; i < `BANK_ENTRIES; i++) begin
                    entryValid[b][i] = 1'b0;
                end
            end
            heldFull = 1'b0;
        end else begin
            drain = heldFull && !bankBusy(held.pc);
            accept = updValid && (!heldFull || drain);
            if (drain) begin
                writeEntry(held);
            end
            if (accept) begin
                heldFull = 1'b1;
                held = '{pc: updPc, target: updTarget, taken: updTaken};
            end else if (drain) begin
                heldFull = 1'b0;
            end
        end
    end

    // Outputs are compared at the falling edge, well after the inputs have settled
    always @(negedge clk) begin
        bankSelT b;
        entryIdxT i;
        addrT expNext;
        logic expTaken;
        logic expReady;
        if (!rstN) begin
            errorCount = 0;
        end else begin
            b = fetchPc[`BANK_MSB:`BANK_LSB];
            i = fetchPc[`INDEX_MSB:`INDEX_LSB];
            expTaken = 1'b0;
            expNext = fetchPc + 32'd4;
            if (redirectValid) begin
                expNext = redirectPc;
            end else if (fetchValid && entryValid[b][i] && entryTag[b][i] == fetchPc &&
                         entryCount[b][i][1]) begin
                // Upper half of the counter range predicts taken
                expTaken = 1'b1;
                expNext = entryTarget[b][i];
            end
            expReady = !heldFull || !bankBusy(held.pc);
            if (nextPc !== expNext || predTaken !== expTaken) begin
                $display("Mismatch at %0t: fetch %h gave nextPc %h predTaken %b, expected %h %b",
                         $time, fetchPc, nextPc, predTaken, expNext, expTaken);
                errorCount++;
            end
            if (updReady !== expReady) begin
                $display("Mismatch at %0t: updReady is %b, expected %b", $time, updReady,
                         expReady);
                errorCount++;
            end
        end
    end

endmodule

`default_nettype wire

/* design/branchPredictor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "predictor_consts.svh"

module branchPredictor import isaPkg::*; (
    input wire logic clk,
    input wire logic rstN,
    input wire logic fetchValid,
    input wire addrT fetchPc,
    input wire logic redirectValid,
    input wire addrT redirectPc,
    output addrT nextPc,
    output logic predTaken,
    input wire logic updValid,
    input wire addrT updPc,
    input wire addrT updTarget,
    input wire logic updTaken,
    output logic updReady
);

    bankLookupIf lookupBus [`NUM_BANKS] ();
    bankUpdateIf updateBus [`NUM_BANKS] ();

    updateRouter router (
        .clk(clk),
        .rstN(rstN),
        .updValid(updValid),
        .updPc(updPc),
        .updTarget(updTarget),
        .updTaken(updTaken),
        .updReady(updReady),
        .bankUpd(updateBus)
    );

    // Every bank is looked up with the fetch PC and the selector keeps one answer
    for (genvar g = 0; g < `NUM_BANKS; g++) begin : genBank
        assign lookupBus[g].pc = fetchPc;

        btbBank bank (
            .clk(clk),
            .rstN(rstN),
            .fetchValid(fetchValid),
            .lookup(lookupBus[g]),
            .upd(updateBus[g])
        );
    end

    predictSelect select (
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .banks(lookupBus),
        .nextPc(nextPc),
        .predTaken(predTaken)
    );

endmodule

`default_nettype wire

/* design/predictSelect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "predictor_consts.svh"

module predictSelect import isaPkg::*; import predictorPkg::*; (
    input wire logic fetchValid,
    input wire addrT fetchPc,
    input wire logic redirectValid,
    input wire addrT redirectPc,
    bankLookupIf.selector banks [`NUM_BANKS],
    output addrT nextPc,
    output logic predTaken
);

    logic [`NUM_BANKS-1:0] bankHit;
    logic [`NUM_BANKS-1:0] bankTaken;
    addrT bankTarget [`NUM_BANKS];
    bankSelT fetchBank;
    logic takeTarget;

    for (genvar g = 0; g < `NUM_BANKS; g++) begin : genCollect
        assign bankHit[g] = banks[g].hit;
        assign bankTaken[g] = banks[g].predTaken;
        assign bankTarget[g] = banks[g].target;
    end

    assign fetchBank = fetchPc[`BANK_MSB:`BANK_LSB];
    assign takeTarget = fetchValid && bankHit[fetchBank] && bankTaken[fetchBank];

    // A redirect from execute beats any prediction
    always_comb begin
        if (redirectValid) begin
            nextPc = redirectPc;
            predTaken = 1'b0;
        end else if (takeTarget) begin
            nextPc = bankTarget[fetchBank];
            predTaken = 1'b1;
        end else begin
            nextPc = fetchPc + addrT'(4);
            predTaken = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/btbBank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "predictor_consts.svh"

module btbBank import isaPkg::*; import predictorPkg::*; (
    input wire logic clk,
    input wire logic rstN,
    input wire logic fetchValid,
    bankLookupIf.bank lookup,
    bankUpdateIf.bank upd
);

    btbEntryT entries [`BANK_ENTRIES];

    entryIdxT rdIdx;
    btbEntryT rdEntry;

    resolveT wrReq;
    entryIdxT wrIdx;
    btbEntryT wrEntry;
    logic wrHit;
    logic wrEn;

    bankSelT fetchBank;
    bankSelT ownBank;

    function automatic counterE stepCounter(counterE cur, logic taken);
        counterE nxt;
        case (cur)
            strongNotTaken: nxt = taken ? weakNotTaken : strongNotTaken;
            weakNotTaken: nxt = taken ? weakTaken : strongNotTaken;
            weakTaken: nxt = taken ? strongTaken : weakNotTaken;
            default: nxt = taken ? strongTaken : weakTaken;
        endcase
        return nxt;
    endfunction

    // Lookup side
    assign rdIdx = lookup.pc[`INDEX_MSB:`INDEX_LSB];
    assign rdEntry = entries[rdIdx];

    assign lookup.hit = rdEntry.valid && (rdEntry.tag == lookup.pc);
    assign lookup.predTaken = (rdEntry.counter == weakTaken) ||
                              (rdEntry.counter == strongTaken);
    assign lookup.target = rdEntry.target;

    // The single port goes to fetch whenever fetch addresses this bank
    assign fetchBank = lookup.pc[`BANK_MSB:`BANK_LSB];
    assign ownBank = wrReq.pc[`BANK_MSB:`BANK_LSB];
    assign upd.ready = !(fetchValid && (fetchBank == ownBank));

    // Update side
    assign wrReq = '{pc: upd.pc, target: upd.target, taken: upd.taken};
    assign wrIdx = wrReq.pc[`INDEX_MSB:`INDEX_LSB];
    assign wrEntry = entries[wrIdx];
    assign wrHit = wrEntry.valid && (wrEntry.tag == wrReq.pc);
    assign wrEn = upd.valid && upd.ready;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `BANK_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (wrEn) begin
            if (wrHit) begin
                entries[wrIdx].counter <= stepCounter(wrEntry.counter, wrReq.taken);
            end else if (wrReq.taken) begin
                // A taken miss takes over the slot, starting weakly taken
                entries[wrIdx] <= '{
                    valid: 1'b1,
                    tag: wrReq.pc,
                    target: wrReq.target,
                    counter: weakTaken
                };
            end
        end
    end

endmodule

`default_nettype wire

/* design/updateRouter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "predictor_consts.svh"

module updateRouter import isaPkg::*; import predictorPkg::*; (
    input wire logic clk,
    input wire logic rstN,
    input wire logic updValid,
    input wire addrT updPc,
    input wire addrT updTarget,
    input wire logic updTaken,
    output logic updReady,
    bankUpdateIf.router bankUpd [`NUM_BANKS]
);

    resolveT held;
    logic full;
    bankSelT heldBank;
    logic [`NUM_BANKS-1:0] bankReady;
    logic drain;
    logic accept;

    assign heldBank = held.pc[`BANK_MSB:`BANK_LSB];

    // The held update leaves in the same cycle its bank takes it
    assign drain = full && bankReady[heldBank];
    assign updReady = !full || drain;
    assign accept = updValid && updReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (drain) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= '{pc: updPc, target: updTarget, taken: updTaken};
        end
    end

    // Each bank sees its own number in the bank bits of pc, which is
    // how it tells that the fetch PC is addressing it
    for (genvar g = 0; g < `NUM_BANKS; g++) begin : genBankUpd
        assign bankUpd[g].valid = full && (heldBank == bankSelT'(g));
        assign bankUpd[g].pc = {held.pc[`WORD_SIZE-1:`BANK_MSB+1], bankSelT'(g),
                                held.pc[`BANK_LSB-1:0]};
        assign bankUpd[g].target = held.target;
        assign bankUpd[g].taken = held.taken;
        assign bankReady[g] = bankUpd[g].ready;
    end

endmodule

`default_nettype wire

/* design/bankIf.sv */
`timescale 1ns/1ps
`default_nettype none

// The lookup path of one bank is combinational from pc to the result
interface bankLookupIf import isaPkg::*; ();

    addrT pc;
    logic hit;
    logic predTaken;
    addrT target;

    modport bank (
        input pc,
        output hit,
        output predTaken,
        output target
    );

    modport selector (
        input hit,
        input predTaken,
        input target
    );

endinterface

// Write request from the router into one bank
interface bankUpdateIf import isaPkg::*; ();

    logic valid;
    logic ready;
    addrT pc;
    addrT target;
    logic taken;

    modport router (
        output valid,
        input ready,
        output pc,
        output target,
        output taken
    );

    modport bank (
        input valid,
        output ready,
        input pc,
        input target,
        input taken
    );

endinterface

`default_nettype wire

/* design/predictorPkg.sv */
`default_nettype none

`include "predictor_consts.svh"

package predictorPkg;

    import isaPkg::*;

    // Two-bit saturating counter whose upper half predicts taken
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken = 2'b01,
        weakTaken = 2'b10,
        strongTaken = 2'b11
    } counterE;

    // Tags are full PCs so aliasing never produces a false hit
    typedef struct packed {
        logic valid;
        addrT tag;
        addrT target;
        counterE counter;
    } btbEntryT;

    typedef logic [`BANK_MSB-`BANK_LSB:0] bankSelT;
    typedef logic [`INDEX_MSB-`INDEX_LSB:0] entryIdxT;

endpackage

`default_nettype wire

/* design/isaPkg.sv */
`default_nettype none

`include "predictor_consts.svh"

package isaPkg;

    // One instruction address
    typedef logic [`WORD_SIZE-1:0] addrT;

    // A branch as resolved by execute
    typedef struct packed {
        addrT pc;
        addrT target;
        logic taken;
    } resolveT;

endpackage

`default_nettype wire

/* design/predictor_consts.svh */
`ifndef PREDICTOR_CONSTS_SVH
`define PREDICTOR_CONSTS_SVH

// Width of an instruction address
`define WORD_SIZE 32

// Table geometry
`define NUM_BANKS 4
`define BANK_ENTRIES 8

// Word-aligned PCs interleave across banks on bits 3:2
`define BANK_LSB 2
`define BANK_MSB 3

// The next three bits pick the entry inside a bank
`define INDEX_LSB 4
`define INDEX_MSB 6

`endif
